/* logic/receiver_pkg.sv */
package receiver_pkg;

	// link geometry
	localparam int lane_count = 4;
	localparam int word_bits = 10;
	localparam int offset_bits = 4; // holds 0..word_bits-1
	localparam int frame_bits = lane_count * word_bits;

	// hunt rule
	localparam int lock_matches = 4; // consecutive good words before locked
	localparam int settle_cycles = 2; // wait after a slip, new offset needs a cycle to show
	localparam int match_count_bits = $clog2(lock_matches + 1);
	localparam int settle_count_bits = $clog2(settle_cycles + 1);

	localparam int error_count_bits = 16; // saturates at all ones

	// apb register map, byte addresses
	localparam int apb_addr_bits = 8;
	localparam int apb_data_bits = 32;
	localparam logic [apb_addr_bits-1:0] addr_control = 8'h00; // [3:0] train, [8] clear_errors
	localparam logic [apb_addr_bits-1:0] addr_pattern = 8'h04;
	localparam logic [apb_addr_bits-1:0] addr_lock = 8'h08;
	localparam logic [apb_addr_bits-1:0] addr_offset = 8'h0C; // 4 bits per lane
	localparam logic [apb_addr_bits-1:0] addr_errors = 8'h10; // plus 4 per lane
	localparam int clear_errors_bit = 8;
	localparam logic [word_bits-1:0] pattern_default = 10'h3E0;

	typedef struct packed {
		logic train;
		logic [word_bits-1:0] pattern;
	} lane_control_t;

	typedef struct packed {
		logic [word_bits-1:0] word; // aligned word
		logic locked;
		logic [offset_bits-1:0] offset;
	} lane_status_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [apb_addr_bits-1:0] paddr;
		logic [apb_data_bits-1:0] pwdata;
	} apb_request_t;

	typedef struct packed {
		logic [apb_data_bits-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_response_t;

endpackage

/* logic/apb_control.sv */
module apb_control (
	input logic word_clock,
	input logic reset,
	input receiver_pkg::apb_request_t apb_in,
	output receiver_pkg::apb_response_t apb_out,
	output receiver_pkg::lane_control_t [receiver_pkg::lane_count-1:0] lane_control,
	input receiver_pkg::lane_status_t [receiver_pkg::lane_count-1:0] lane_status,
	input logic [receiver_pkg::lane_count-1:0][receiver_pkg::error_count_bits-1:0] error_counts,
	output logic clear_errors
);
	logic [receiver_pkg::lane_count-1:0] train_bits; // one enable per lane
	logic [receiver_pkg::word_bits-1:0] pattern; // shared by all lanes
	logic access; // second cycle of a transfer
	logic write_access;
	logic mapped;
	logic [receiver_pkg::apb_data_bits-1:0] read_word;

	assign access = apb_in.psel & apb_in.penable;
	assign write_access = access & apb_in.pwrite;

	// one cycle pulse, counters clear on the edge ending the write
	assign clear_errors = write_access && apb_in.paddr == receiver_pkg::addr_control
		&& apb_in.pwdata[receiver_pkg::clear_errors_bit];

	always_ff @(posedge word_clock) begin
		if (reset) begin
			train_bits <= '0;
			pattern <= receiver_pkg::pattern_default;
		end else if (write_access) begin
			case (apb_in.paddr)
				receiver_pkg::addr_control: train_bits <= apb_in.pwdata[receiver_pkg::lane_count-1:0];
				receiver_pkg::addr_pattern: pattern <= apb_in.pwdata[receiver_pkg::word_bits-1:0];
				default: ; // read only or unmapped, nothing stored
			endcase
		end
	end

	// read mux, everything here is already registered
	always_comb begin
		read_word = '0;
		mapped = 1'b1;
		case (apb_in.paddr)
			receiver_pkg::addr_control: read_word[receiver_pkg::lane_count-1:0] = train_bits;
			receiver_pkg::addr_pattern: read_word[receiver_pkg::word_bits-1:0] = pattern;
			receiver_pkg::addr_lock: begin
				for (int i = 0; i < receiver_pkg::lane_count; i++) begin
					read_word[i] = lane_status[i].locked;
				end
			end
			receiver_pkg::addr_offset: begin
				for (int i = 0; i < receiver_pkg::lane_count; i++) begin
					read_word[i*receiver_pkg::offset_bits +: receiver_pkg::offset_bits] =
						lane_status[i].offset; // lane 0 in the low nibble
				end
			end
			default: begin
				mapped = 1'b0;
				for (int i = 0; i < receiver_pkg::lane_count; i++) begin
					if (apb_in.paddr == receiver_pkg::apb_addr_bits'(receiver_pkg::addr_errors + 4*i)) begin
						read_word[receiver_pkg::error_count_bits-1:0] = error_counts[i];
						mapped = 1'b1;
					end
				end
			end
		endcase
	end

	// response is quiet outside the access cycle
	assign apb_out.prdata = (access && !apb_in.pwrite && mapped) ? read_word : '0;
	assign apb_out.pready = 1'b1; // never stalls
	assign apb_out.pslverr = access & ~mapped;

	always_comb begin
		for (int i = 0; i < receiver_pkg::lane_count; i++) begin
			lane_control[i].train = train_bits[i];
			lane_control[i].pattern = pattern;
		end
	end

endmodule

/* logic/word_aligner.sv */
module word_aligner (
	input logic word_clock,
	input logic reset,
	input logic [receiver_pkg::word_bits-1:0] raw_word,
	input receiver_pkg::lane_control_t lane_control,
	output receiver_pkg::lane_status_t lane_status
);
	logic [receiver_pkg::word_bits-1:0] previous_word; // raw word of the last cycle
	logic [2*receiver_pkg::word_bits-1:0] window;
	logic [receiver_pkg::word_bits-1:0] aligned_word;
	logic [receiver_pkg::offset_bits-1:0] offset;
	logic locked;
	logic [receiver_pkg::match_count_bits-1:0] match_count;
	logic [receiver_pkg::settle_count_bits-1:0] settle_count;
	logic train_previous; // for edge detect
	logic train_rise;
	logic hunting;
	logic match;

	assign window = {raw_word, previous_word}; // current word on top

	// bitslip, aligned word lands one cycle after its raw word
	always_ff @(posedge word_clock) begin
		previous_word <= raw_word;
		aligned_word <= window[offset +: receiver_pkg::word_bits];
	end

	assign train_rise = lane_control.train & ~train_previous;
	assign hunting = lane_control.train & ~locked;
	assign match = aligned_word == lane_control.pattern;

	always_ff @(posedge word_clock) begin
		if (reset) begin
			train_previous <= 1'b0;
			offset <= '0;
			locked <= 1'b0;
			match_count <= '0;
			settle_count <= '0;
		end else begin
			train_previous <= lane_control.train;
			if (train_rise) begin // retrain from the offset we have
				locked <= 1'b0;
				match_count <= '0;
				settle_count <= '0;
			end else if (hunting) begin
				if (settle_count != '0) begin
					settle_count <= settle_count - 1'b1; // old offset still in the pipe
				end else if (match) begin
					match_count <= match_count + 1'b1;
					locked <= match_count == receiver_pkg::lock_matches - 1;
				end else begin
					// slip one bit, wrap at the end of the word
					offset <= (offset == receiver_pkg::word_bits - 1) ? '0 : offset + 1'b1;
					settle_count <= receiver_pkg::settle_count_bits'(receiver_pkg::settle_cycles);
					match_count <= '0;
				end
			end
			// train low, offset and locked just hold
		end
	end

	assign lane_status.word = aligned_word;
	assign lane_status.locked = locked;
	assign lane_status.offset = offset;

endmodule

/* logic/lane_collector.sv */
module lane_collector (
	input logic word_clock,
	input logic reset,
	input receiver_pkg::lane_status_t [receiver_pkg::lane_count-1:0] lane_status,
	input receiver_pkg::lane_control_t [receiver_pkg::lane_count-1:0] lane_control,
	input logic clear_errors,
	output logic [receiver_pkg::frame_bits-1:0] frame_word,
	output logic frame_valid,
	output logic [receiver_pkg::lane_count-1:0][receiver_pkg::error_count_bits-1:0] error_counts
);
	logic all_locked;
	logic [receiver_pkg::lane_count-1:0] lane_error; // locked lane saw a bad word

	always_comb begin
		all_locked = 1'b1;
		for (int i = 0; i < receiver_pkg::lane_count; i++) begin
			all_locked = all_locked & lane_status[i].locked;
			lane_error[i] = lane_status[i].locked & lane_control[i].train
				& (lane_status[i].word != lane_control[i].pattern);
		end
	end

	// frame register, lane 0 in the low bits
	always_ff @(posedge word_clock) begin
		for (int i = 0; i < receiver_pkg::lane_count; i++) begin
			frame_word[i*receiver_pkg::word_bits +: receiver_pkg::word_bits] <= lane_status[i].word;
		end
	end

	always_ff @(posedge word_clock) begin
		if (reset) begin
			frame_valid <= 1'b0;
			error_counts <= '0;
		end else begin
			frame_valid <= all_locked; // goes with the frame word of the same edge
			for (int i = 0; i < receiver_pkg::lane_count; i++) begin
				if (clear_errors) begin
					error_counts[i] <= '0;
				end else if (lane_error[i] && error_counts[i] != '1) begin
					error_counts[i] <= error_counts[i] + 1'b1; // stops at full scale
				end
			end
		end
	end

endmodule

/* logic/receiver_top.sv */
module receiver_top (
	input logic word_clock,
	input logic reset,
	input logic [receiver_pkg::lane_count-1:0][receiver_pkg::word_bits-1:0] raw_words,
	input receiver_pkg::apb_request_t apb_in,
	output receiver_pkg::apb_response_t apb_out,
	output logic [receiver_pkg::frame_bits-1:0] frame_word,
	output logic frame_valid
);
	receiver_pkg::lane_control_t [receiver_pkg::lane_count-1:0] lane_control; // apb to lanes
	receiver_pkg::lane_status_t [receiver_pkg::lane_count-1:0] lane_status; // lanes out
	logic [receiver_pkg::lane_count-1:0][receiver_pkg::error_count_bits-1:0] error_counts;
	logic clear_errors;

	apb_control control (
		.word_clock(word_clock),
		.reset(reset),
		.apb_in(apb_in),
		.apb_out(apb_out),
		.lane_control(lane_control),
		.lane_status(lane_status),
		.error_counts(error_counts),
		.clear_errors(clear_errors)
	);

	// one aligner per lane, all the same
	for (genvar i = 0; i < receiver_pkg::lane_count; i++) begin : lane
		word_aligner aligner (
			.word_clock(word_clock),
			.reset(reset),
			.raw_word(raw_words[i]),
			.lane_control(lane_control[i]),
			.lane_status(lane_status[i])
		);
	end

	lane_collector collector (
		.word_clock(word_clock),
		.reset(reset),
		.lane_status(lane_status),
		.lane_control(lane_control),
		.clear_errors(clear_errors),
		.frame_word(frame_word),
		.frame_valid(frame_valid),
		.error_counts(error_counts)
	);

endmodule

/* test/receiver_sva.sv */
module receiver_sva (
	input logic word_clock,
	input logic reset,
	input receiver_pkg::apb_request_t apb_in,
	input receiver_pkg::apb_response_t apb_out,
	input logic frame_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	int failure_count = 0; // failed assertions so far, the testbench folds this into its verdict

	// slave never stalls
	pready_high: assert property (@(posedge word_clock) apb_out.pready)
		else begin
			$error("pready went low");
			failure_count++;
		end

	slverr_in_access: assert property (@(posedge word_clock)
		apb_out.pslverr |-> apb_in.psel && apb_in.penable)
		else begin
			$error("pslverr outside an access cycle");
			failure_count++;
		end

	// read data stays quiet between transfers
	quiet_outside_access: assert property (@(posedge word_clock)
		!(apb_in.psel && apb_in.penable) |-> apb_out.prdata == '0)
		else begin
			$error("prdata active outside an access cycle");
			failure_count++;
		end

	valid_low_in_reset: assert property (@(posedge word_clock) reset |=> !frame_valid)
		else begin
			$error("frame_valid high after a reset edge");
			failure_count++;
		end

endmodule

bind receiver_top receiver_sva sva (.*);

/* test/clock_source.sv */
module clock_source (
	output logic word_clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		word_clock = 1'b0;
		forever #4 word_clock = ~word_clock; // 8 ns period
	end

	// reset covers 8 rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (8) @(posedge word_clock);
		@(negedge word_clock);
		reset = 1'b0;
	end

endmodule

/* test/receiver_checker.sv */
module receiver_checker (
	input logic word_clock,
	input logic reset,
	input receiver_pkg::apb_request_t apb_in,
	input receiver_pkg::apb_response_t apb_out,
	input logic [receiver_pkg::frame_bits-1:0] frame_word,
	input logic frame_valid,
	input logic read_check, // compare this access
	input logic [receiver_pkg::apb_data_bits-1:0] expected_rdata,
	input logic expected_slverr,
	input logic frame_check, // all lanes locked on the current pattern
	input logic frame_idle, // no lane trained yet
	input logic [receiver_pkg::word_bits-1:0] frame_pattern,
	input logic run_done,
	input int timeout_count,
	input int assertion_count,
	output int mismatch_count
);
	timeunit 1ns;
	timeprecision 100ps;

	initial mismatch_count = 0;

	task automatic report_mismatch(input string message);
		$display("CHECK FAILED at %0t: %s", $time, message);
		mismatch_count++;
	endtask

	// everything sampled on the rising edge, inputs move on the falling one
	always @(posedge word_clock) begin
		if (!reset && read_check && apb_in.psel && apb_in.penable) begin
			if (apb_out.prdata !== expected_rdata)
				report_mismatch($sformatf("addr 0x%02h prdata 0x%08h, expected 0x%08h",
					apb_in.paddr, apb_out.prdata, expected_rdata));
			if (apb_out.pslverr !== expected_slverr)
				report_mismatch($sformatf("addr 0x%02h pslverr %b, expected %b",
					apb_in.paddr, apb_out.pslverr, expected_slverr));
		end
		if (!reset && frame_idle && frame_valid !== 1'b0)
			report_mismatch("frame_valid high before any lane trained");
		if (!reset && frame_check) begin
			if (frame_valid !== 1'b1) begin
				report_mismatch("frame_valid low while all lanes locked");
			end else begin
				for (int i = 0; i < receiver_pkg::lane_count; i++) begin
					// lane 0 sits in the low bits
					if (frame_word[i*receiver_pkg::word_bits +: receiver_pkg::word_bits]
						!== frame_pattern)
						report_mismatch($sformatf("lane %0d frame field 0x%03h, expected 0x%03h",
							i, frame_word[i*receiver_pkg::word_bits +: receiver_pkg::word_bits],
							frame_pattern));
				end
			end
		end
	end

	always @(posedge run_done) begin
		$display("checks done: %0d value mismatches, %0d timeouts, %0d assertion failures",
			mismatch_count, timeout_count, assertion_count);
	end

endmodule

/* test/receiver_tb.sv */
module receiver_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [receiver_pkg::word_bits-1:0] pattern;
		logic [receiver_pkg::lane_count-1:0][3:0] delay; // bit delay, lane 0 low
		logic [receiver_pkg::lane_count-1:0][3:0] corrupt; // words spoiled per lane
	} case_row_t;

	// every pattern has ten distinct rotations
	case_row_t cases [3] = '{
		'{10'h17C, {4'd5, 4'd9, 4'd0, 4'd3}, {4'd3, 4'd1, 4'd0, 4'd2}},
		'{10'h283, {4'd8, 4'd4, 4'd1, 4'd7}, {4'd1, 4'd0, 4'd2, 4'd1}},
		'{10'h0F9, {4'd9, 4'd2, 4'd6, 4'd0}, {4'd2, 4'd3, 4'd1, 4'd0}}
	};

	logic word_clock;
	logic reset;
	logic [receiver_pkg::lane_count-1:0][receiver_pkg::word_bits-1:0] raw_words = '0;
	receiver_pkg::apb_request_t apb_in;
	receiver_pkg::apb_response_t apb_out;
	logic [receiver_pkg::frame_bits-1:0] frame_word;
	logic frame_valid;
	logic read_check;
	logic [receiver_pkg::apb_data_bits-1:0] expected_rdata;
	logic expected_slverr;
	logic frame_check;
	logic frame_idle;
	logic [receiver_pkg::word_bits-1:0] frame_pattern;
	logic run_done;
	int timeout_count;
	int assertion_count; // failures of the bound assertions
	int mismatch_count;
	logic [receiver_pkg::apb_data_bits-1:0] read_word; // prdata of the last access
	logic [receiver_pkg::word_bits-1:0] drive_pattern;
	int drive_delay [receiver_pkg::lane_count];
	int word_index = 0; // raw words driven so far
	logic [receiver_pkg::word_bits-1:0] flip_table [receiver_pkg::lane_count][4096];

	clock_source clocks (.*);
	receiver_top DUT (.*);
	receiver_checker scoreboard (.*);

	assign assertion_count = DUT.sva.failure_count;

	// stream bit n carries pattern bit (n - delay) mod 10, word k holds bits 10k..10k+9
	function automatic logic [receiver_pkg::word_bits-1:0] make_raw(
			input logic [receiver_pkg::word_bits-1:0] pattern, input int delay, input int k);
		logic [receiver_pkg::word_bits-1:0] word;
		for (int j = 0; j < receiver_pkg::word_bits; j++) begin
			word[j] = pattern[(receiver_pkg::word_bits * (k + 1) + j - delay)
				% receiver_pkg::word_bits];
		end
		return word;
	endfunction

	function automatic int find_offset(input logic [receiver_pkg::word_bits-1:0] pattern,
			input int delay);
		logic [2*receiver_pkg::word_bits-1:0] window;
		window = {make_raw(pattern, delay, 1), make_raw(pattern, delay, 0)}; // newer on top
		for (int o = 0; o < receiver_pkg::word_bits; o++) begin
			if (window[o +: receiver_pkg::word_bits] == pattern) begin
				return o;
			end
		end
		return -1;
	endfunction

	function automatic logic [31:0] offset_word(input int row);
		logic [31:0] word;
		word = '0;
		for (int i = 0; i < receiver_pkg::lane_count; i++) begin
			word[i*4 +: 4] = 4'(find_offset(cases[row].pattern, cases[row].delay[i]));
		end
		return word;
	endfunction

	function automatic logic [7:0] error_addr(input int lane);
		return 8'(receiver_pkg::addr_errors + 4 * lane);
	endfunction

	task automatic report_timeout(input string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		timeout_count++;
	endtask

	task automatic transfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
			input logic check, input logic [31:0] expected, input logic slverr);
		int guard;
		@(negedge word_clock); // setup cycle
		apb_in = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		read_check = check;
		expected_rdata = expected;
		expected_slverr = slverr;
		@(negedge word_clock);
		apb_in.penable = 1'b1;
		guard = 0;
		do begin
			@(posedge word_clock);
			guard++;
		end while (!apb_out.pready && guard < 16);
		if (!apb_out.pready) report_timeout("pready on an APB access");
		read_word = apb_out.prdata;
		@(negedge word_clock);
		apb_in = '0;
		read_check = 1'b0;
	endtask

	task automatic write_register(input logic [7:0] addr, input logic [31:0] data, input logic err);
		transfer(1'b1, addr, data, 1'b1, '0, err); // writes read back 0
	endtask

	task automatic expect_register(input logic [7:0] addr, input logic [31:0] data, input logic err);
		transfer(1'b0, addr, '0, 1'b1, data, err);
	endtask

	task automatic wait_for_lock();
		int polls;
		polls = 0;
		read_word = '0;
		while (read_word[3:0] != 4'hF && polls < 100) begin
			transfer(1'b0, receiver_pkg::addr_lock, '0, 1'b0, '0, 1'b0);
			polls++;
		end
		if (read_word[3:0] != 4'hF) report_timeout("all lanes to lock");
	endtask

	// flips one bit at or above the lane offset, so each hits a single aligned word
	task automatic corrupt_words(input int row);
		int next;
		int last;
		int offset;
		int guard;
		@(posedge word_clock);
		last = word_index;
		for (int i = 0; i < receiver_pkg::lane_count; i++) begin
			next = word_index + 4;
			offset = find_offset(cases[row].pattern, cases[row].delay[i]);
			for (int n = 0; n < cases[row].corrupt[i]; n++) begin
				flip_table[i][next % 4096] = 10'b1 << (offset + int'($urandom % (10 - offset)));
				last = (next > last) ? next : last;
				next = next + 2 + int'($urandom % 4);
			end
		end
		guard = 0;
		while (word_index < last + 6 && guard < 200) begin
			@(posedge word_clock);
			guard++;
		end
		if (word_index < last + 6) report_timeout("spoiled words to reach the counters");
	endtask

	task automatic run_row(input int row, input logic [31:0] held);
		write_register(receiver_pkg::addr_control, 32'h0, 1'b0); // train off
		@(posedge word_clock);
		drive_pattern = cases[row].pattern;
		for (int i = 0; i < receiver_pkg::lane_count; i++) drive_delay[i] = cases[row].delay[i];
		write_register(receiver_pkg::addr_pattern, 32'(cases[row].pattern), 1'b0);
		expect_register(receiver_pkg::addr_pattern, 32'(cases[row].pattern), 1'b0);
		expect_register(receiver_pkg::addr_offset, held, 1'b0); // no slip with train low
		write_register(receiver_pkg::addr_control, 32'hF, 1'b0);
		wait_for_lock();
		expect_register(receiver_pkg::addr_offset, offset_word(row), 1'b0);
		@(negedge word_clock);
		frame_pattern = cases[row].pattern;
		frame_check = 1'b1;
		repeat (32) @(posedge word_clock);
		@(negedge word_clock);
		frame_check = 1'b0;
		write_register(receiver_pkg::addr_control, 32'h10F, 1'b0);
		expect_register(receiver_pkg::addr_control, 32'hF, 1'b0); // clear bit not kept
		for (int i = 0; i < receiver_pkg::lane_count; i++) expect_register(error_addr(i), 0, 1'b0);
		corrupt_words(row);
		for (int i = 0; i < receiver_pkg::lane_count; i++)
			expect_register(error_addr(i), 32'(cases[row].corrupt[i]), 1'b0);
		write_register(receiver_pkg::addr_control, 32'h10F, 1'b0);
		for (int i = 0; i < receiver_pkg::lane_count; i++) expect_register(error_addr(i), 0, 1'b0);
	endtask

	// raw words go out on the falling edge
	always @(negedge word_clock) begin
		for (int i = 0; i < receiver_pkg::lane_count; i++) begin
			raw_words[i] = make_raw(drive_pattern, drive_delay[i], word_index)
				^ flip_table[i][word_index % 4096];
		end
		word_index = word_index + 1;
	end

	initial begin
		int guard;
		void'($urandom(47));
		apb_in = '0;
		read_check = 1'b0;
		expected_rdata = '0;
		expected_slverr = 1'b0;
		frame_check = 1'b0;
		frame_idle = 1'b1;
		frame_pattern = '0;
		run_done = 1'b0;
		timeout_count = 0;
		drive_pattern = receiver_pkg::pattern_default;
		foreach (drive_delay[i]) drive_delay[i] = 0;
		foreach (flip_table[i, j]) flip_table[i][j] = '0;
		guard = 0;
		while (reset !== 1'b0 && guard < 50) begin
			@(posedge word_clock);
			guard++;
		end
		if (reset !== 1'b0) report_timeout("reset to be released");
		expect_register(receiver_pkg::addr_lock, '0, 1'b0);
		expect_register(receiver_pkg::addr_offset, '0, 1'b0);
		expect_register(receiver_pkg::addr_pattern, 32'h3E0, 1'b0);
		expect_register(8'h20, '0, 1'b1); // unmapped read
		write_register(8'h40, 32'hFFFF_FFFF, 1'b1);
		frame_idle = 1'b0;
		for (int row = 0; row < $size(cases); row++) begin
			run_row(row, (row == 0) ? 32'h0 : offset_word(row - 1));
		end
		run_done = 1'b1;
		#1;
		if (mismatch_count == 0 && timeout_count == 0 && assertion_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
logic/receiver_pkg.sv
logic/apb_control.sv
logic/word_aligner.sv
logic/lane_collector.sv
logic/receiver_top.sv
test/receiver_sva.sv
test/clock_source.sv
test/receiver_checker.sv
test/receiver_tb.sv
